// ==== Makefile ====
SIM := obj_dir/CoreTb
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the file list changes
$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f all.f --top-module CoreTb \
		-Mdir obj_dir -o CoreTb

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
verilog/CorePkg.sv
verilog/ChannelFifo.sv
verilog/PcParser.sv
verilog/BdEncoder.sv
verilog/TimeMgr.sv
verilog/PcPacker.sv
verilog/Core.sv
tests/CoreTb.sv

// ==== tests/CoreTb.sv ====
module CoreTb;
  timeunit 1ns;
  timeprecision 1ps;

  import CorePkg::*;

  localparam int NumStim = 24;
  localparam int NumUp = 12;
  localparam int NumMixed = 20;
  localparam int Timeout = 500;
  // Codes outside the register and leaf ranges
  localparam logic [3:0][PcCodeW-1:0] DropCodes = {8'hFF, 8'h88, 8'hC0, 8'h20};

  logic clk;
  logic arstN;
  logic pcInValid;
  logic [PcWordW-1:0] pcInData;
  logic pcInReady;
  logic pcOutValid;
  logic [PcWordW-1:0] pcOutData;
  logic pcOutReady;
  logic bdOutValid;
  logic [BdWordW-1:0] bdOutData;
  logic bdOutReady;
  logic bdInValid;
  logic [BdWordW-1:0] bdInData;
  logic bdInReady;
  logic pReset;
  logic sReset;

  // Stimulus table, PC word with its expected chip word if any
  logic [PcWordW-1:0] stimWord [NumStim];
  bit stimHasOut [NumStim];
  logic [BdWordW-1:0] stimExp [NumStim];

  // Words seen on the outputs
  logic [BdWordW-1:0] bdOutQ [$];
  logic [PcWordW-1:0] pcOutQ [$];

  bit stallBd;
  bit stallPc;
  int errors;
  int errStart;
  int checks;
  int testsRun;

  Core Core_i (
    .clk, .arstN,
    .pcInValid, .pcInData, .pcInReady,
    .pcOutValid, .pcOutData, .pcOutReady,
    .bdOutValid, .bdOutData, .bdOutReady,
    .bdInValid, .bdInData, .bdInReady,
    .pReset, .sReset);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Output ready, random stalls when enabled
  initial begin
    bdOutReady = 1'b1;
    pcOutReady = 1'b1;
    forever begin
      @(negedge clk);
      bdOutReady = stallBd ? (($urandom % 3) != 0) : 1'b1;
      pcOutReady = stallPc ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  // Monitors, transfers happen at the rising edge
  always @(posedge clk) begin
    if (bdOutValid && bdOutReady) bdOutQ.push_back(bdOutData);
    if (pcOutValid && pcOutReady) pcOutQ.push_back(pcOutData);
  end

  //////////////////////////////////////////////////////////////
  // Reference model

  // Leaf route on top, payload cut to the leaf width
  function automatic logic [BdWordW-1:0] routedWord(input logic [LeafW-1:0] leaf,
                                                    input logic [PcDataW-1:0] data);
    logic [PcDataW-1:0] kept;
    kept = '0;
    for (int b = 0; b < PcDataW; b++) begin
      if (b < int'(LeafWidth[leaf])) kept[b] = data[b];
    end
    return {LeafRoute[leaf], kept};
  endfunction

  // Upstream code is base plus route
  function automatic logic [PcWordW-1:0] packedWord(input logic [BdWordW-1:0] w);
    logic [PcCodeW-1:0] code;
    code = CodeBdBase + {4'h0, w[BdWordW-1 -: RouteW]};
    return {code, w[PcDataW-1:0]};
  endfunction

  //////////////////////////////////////////////////////////////
  // Helpers

  task automatic reportMismatch(input string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    $display("Test %0d %s done, %0d errors", testsRun, name, errors - errStart);
    errStart = errors;
  endtask

  // Called at a falling edge, returns at a falling edge
  task automatic sendPc(input logic [PcWordW-1:0] word);
    int cnt;
    cnt = 0;
    pcInValid = 1'b1;
    pcInData = word;
    while (!pcInReady && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    if (!pcInReady) begin
      errors++;
      $display("Timeout: the pcIn channel never became ready");
    end
    @(negedge clk);
    pcInValid = 1'b0;
  endtask

  task automatic sendBd(input logic [BdWordW-1:0] word);
    int cnt;
    cnt = 0;
    bdInValid = 1'b1;
    bdInData = word;
    while (!bdInReady && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    if (!bdInReady) begin
      errors++;
      $display("Timeout: the bdIn channel never became ready");
    end
    @(negedge clk);
    bdInValid = 1'b0;
  endtask

  task automatic waitWords(input bit fromPc, input int n, output bit ok);
    int cnt;
    cnt = 0;
    while ((fromPc ? pcOutQ.size() : bdOutQ.size()) < n && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    ok = (fromPc ? pcOutQ.size() : bdOutQ.size()) >= n;
    if (!ok) begin
      errors++;
      $display("Timeout: %s delivered fewer than %0d words", fromPc ? "pcOut" : "bdOut", n);
    end
  endtask

  task automatic waitResetBits(input logic p, input logic s);
    int cnt;
    cnt = 0;
    while ((pReset !== p || sReset !== s) && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    checks++;
    if (pReset !== p || sReset !== s) begin
      errors++;
      $display("Timeout: chip reset outputs never reached pReset %b sReset %b", p, s);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Tests

  task automatic buildTable();
    logic [31:0] rnd;
    logic [LeafW-1:0] leaf;
    logic [1:0] dropSel;
    for (int i = 0; i < NumStim; i++) begin
      rnd = $urandom;
      leaf = LeafW'(i % NumLeaves);
      // Second part mixes dropped codes between leaf words
      if (i >= 16 && i % 2 == 0) begin
        dropSel = 2'((i - 16) / 2);
        stimWord[i] = {DropCodes[dropSel], rnd[PcDataW-1:0]};
        stimHasOut[i] = 1'b0;
        stimExp[i] = '0;
      end else begin
        stimWord[i] = {CodeBdBase + {5'h0, leaf}, rnd[PcDataW-1:0]};
        stimHasOut[i] = 1'b1;
        stimExp[i] = routedWord(leaf, rnd[PcDataW-1:0]);
      end
    end
  endtask

  task automatic applyTable(input int first, input int last, input string name);
    logic [BdWordW-1:0] expQ [$];
    logic [BdWordW-1:0] got;
    bit ok;
    for (int i = first; i <= last; i++) begin
      sendPc(stimWord[i]);
      if (stimHasOut[i]) expQ.push_back(stimExp[i]);
    end
    waitWords(1'b0, expQ.size(), ok);
    for (int k = 0; k < expQ.size() && bdOutQ.size() > 0; k++) begin
      got = bdOutQ.pop_front();
      checks++;
      if (got !== expQ[k]) begin
        reportMismatch($sformatf("bdOut word %0d is %h, expected %h", k, got, expQ[k]));
      end
    end
    finishTest(name);
  endtask

  task automatic resetTest();
    checks++;
    if (pReset !== 1'b1 || sReset !== 1'b1) reportMismatch("reset outputs low after reset");
    checks++;
    if (bdOutValid !== 1'b0 || pcOutValid !== 1'b0) reportMismatch("valid high after reset");
    sendPc({CodeRegReset, 24'd0});
    waitResetBits(1'b0, 1'b0);
    sendPc({CodeRegReset, 24'd2});
    waitResetBits(1'b0, 1'b1);
    finishTest("reset outputs");
  endtask

  task automatic upTest();
    logic [PcWordW-1:0] expQ [$];
    logic [31:0] rnd;
    logic [PcWordW-1:0] got;
    bit ok;
    stallPc = 1'b1;
    sendPc({CodeRegHb, 24'd0});
    for (int i = 0; i < NumUp; i++) begin
      rnd = $urandom;
      sendBd(rnd[BdWordW-1:0]);
      expQ.push_back(packedWord(rnd[BdWordW-1:0]));
    end
    waitWords(1'b1, NumUp, ok);
    for (int k = 0; k < NumUp && pcOutQ.size() > 0; k++) begin
      got = pcOutQ.pop_front();
      checks++;
      if (got !== expQ[k]) begin
        reportMismatch($sformatf("pcOut word %0d is %h, expected %h", k, got, expQ[k]));
      end
    end
    stallPc = 1'b0;
    finishTest("upstream packing");
  endtask

  task automatic hbTest();
    logic [PcWordW-1:0] lo;
    logic [PcWordW-1:0] hi;
    logic [TimeW-1:0] t;
    logic [TimeW-1:0] prev;
    bit ok;
    // Period first so the unit count starts with time
    sendPc({CodeRegHb, 24'd3});
    sendPc({CodeRegUnit, 24'd4});
    prev = '0;
    for (int p = 0; p < 4; p++) begin
      waitWords(1'b1, 2, ok);
      if (!ok) break;
      lo = pcOutQ.pop_front();
      hi = pcOutQ.pop_front();
      checks++;
      if (lo[PcWordW-1 -: PcCodeW] !== CodeHbLo || hi[PcWordW-1 -: PcCodeW] !== CodeHbHi) begin
        reportMismatch($sformatf("heartbeat pair %0d has words %h %h", p, lo, hi));
      end
      t = {hi[PcDataW-1:0], lo[PcDataW-1:0]};
      checks++;
      if (t == '0 || t % 3 != 0) reportMismatch($sformatf("heartbeat time %0d", t));
      if (p > 0) begin
        checks++;
        if (t != prev + 3) reportMismatch($sformatf("time %0d follows %0d", t, prev));
      end
      prev = t;
    end
    finishTest("heartbeats");
  endtask

  task automatic mixedTest();
    logic [BdWordW-1:0] words [NumMixed];
    logic [31:0] rnd;
    logic [PcWordW-1:0] w;
    int dataSeen;
    int pairs;
    bit ok;
    sendPc({CodeRegHb, 24'd0});
    for (int i = 0; i < NumMixed; i++) begin
      rnd = $urandom;
      words[i] = rnd[BdWordW-1:0];
    end
    stallPc = 1'b1;
    fork
      begin
        for (int i = 0; i < NumMixed; i++) sendBd(words[i]);
      end
      sendPc({CodeRegHb, 24'd1});
    join
    dataSeen = 0;
    pairs = 0;
    // Leftover pairs from the last test are fine here
    while (dataSeen < NumMixed) begin
      waitWords(1'b1, 1, ok);
      if (!ok) break;
      w = pcOutQ.pop_front();
      if (w[PcWordW-1 -: PcCodeW] == CodeHbLo) begin
        waitWords(1'b1, 1, ok);
        if (!ok) break;
        w = pcOutQ.pop_front();
        checks++;
        if (w[PcWordW-1 -: PcCodeW] !== CodeHbHi) reportMismatch($sformatf("HbLo then %h", w));
        // Only pairs after the first data word were mixed into traffic
        if (dataSeen > 0) pairs++;
      end else begin
        checks++;
        if (w !== packedWord(words[dataSeen])) begin
          reportMismatch($sformatf("data word %0d is %h, expected %h",
                                   dataSeen, w, packedWord(words[dataSeen])));
        end
        dataSeen++;
      end
    end
    checks++;
    if (pairs == 0) reportMismatch("no heartbeat pair between data words");
    stallPc = 1'b0;
    finishTest("heartbeat during traffic");
  endtask

  //////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(32'hc6601593));
    arstN = 1'b0;
    pcInValid = 1'b0;
    pcInData = '0;
    bdInValid = 1'b0;
    bdInData = '0;
    stallBd = 1'b0;
    stallPc = 1'b0;
    errors = 0;
    errStart = 0;
    checks = 0;
    testsRun = 0;
    buildTable();
    repeat (8) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    resetTest();
    stallBd = 1'b1;
    applyTable(0, 15, "downstream encoding");
    applyTable(16, NumStim - 1, "dropped codes");
    stallBd = 1'b0;
    upTest();
    hbTest();
    mixedTest();

    $display("Tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/BdEncoder.sv ====
module BdEncoder (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          inValid,
  input  logic [CorePkg::LeafW-1:0]     inLeaf,
  input  logic [CorePkg::PcDataW-1:0]   inData,
  output logic                          inReady,
  output logic                          outValid,
  output logic [CorePkg::BdWordW-1:0]   outData,
  input  logic                          outReady
);

  import CorePkg::*;

  logic [RouteW-1:0] route;
  logic [PcDataW-1:0] mask;
  logic take;

  // Table lookups
  assign route = LeafRoute[inLeaf];
  // Ones below leaf width, full width gives all ones
  assign mask = ~({PcDataW{1'b1}} << LeafWidth[inLeaf]);

  assign inReady = !outValid || outReady;
  assign take = inValid && inReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) outValid <= 1'b0;
    else if (inReady) outValid <= inValid;
  end

  // Route on top, masked payload below
  always_ff @(posedge clk) begin
    if (take) outData <= {route, inData & mask};
  end

  // Chip word held under stall
  holdOut: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> outValid && $stable(outData));

endmodule

// ==== verilog/ChannelFifo.sv ====
module ChannelFifo #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             inValid,
  input  logic [Width-1:0] inData,
  output logic             inReady,
  output logic             outValid,
  output logic [Width-1:0] outData,
  input  logic             outReady
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountW = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CountW-1:0] count;
  logic full;
  logic wrEn;
  logic rdEn;

  assign full = count == CountW'(Depth);
  assign inReady = !full;
  assign outValid = count != '0;
  // Head of queue, no output register
  assign outData = mem[rdPtr];
  assign wrEn = inValid && inReady;
  assign rdEn = outValid && outReady;

  // Storage
  always_ff @(posedge clk) begin
    if (wrEn) mem[wrPtr] <= inData;
  end

  // Pointers wrap at Depth, any depth allowed
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (rdEn) rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      case ({wrEn, rdEn})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Full and nothing read, so no write may land
  noWriteFull: assert property (@(posedge clk) disable iff (!arstN)
    full && !rdEn |=> $stable(wrPtr) && full);

  // Head word held under stall
  holdOut: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> outValid && $stable(outData));

endmodule

// ==== verilog/Core.sv ====
module Core (
  input  logic                          clk,
  input  logic                          arstN,
  // PC side
  input  logic                          pcInValid,
  input  logic [CorePkg::PcWordW-1:0]   pcInData,
  output logic                          pcInReady,
  output logic                          pcOutValid,
  output logic [CorePkg::PcWordW-1:0]   pcOutData,
  input  logic                          pcOutReady,
  // Chip side
  output logic                          bdOutValid,
  output logic [CorePkg::BdWordW-1:0]   bdOutData,
  input  logic                          bdOutReady,
  input  logic                          bdInValid,
  input  logic [CorePkg::BdWordW-1:0]   bdInData,
  output logic                          bdInReady,
  output logic                          pReset,
  output logic                          sReset
);

  import CorePkg::*;

  // PC input FIFO to parser
  logic pcFifoValid;
  logic [PcWordW-1:0] pcFifoData;
  logic pcFifoReady;

  // Parser to encoder
  logic bdValid;
  logic [LeafW-1:0] bdLeaf;
  logic [PcDataW-1:0] bdData;
  logic bdReady;

  // Chip input FIFO to packer
  logic bdFifoValid;
  logic [BdWordW-1:0] bdFifoData;
  logic bdFifoReady;

  // Config and time
  logic [RegW-1:0] unitCycles;
  logic [RegW-1:0] hbUnits;
  logic hbReq;
  logic hbAck;
  logic [TimeW-1:0] timeElapsed;

  //////////////////////////////////////////////////////////////
  // PC to chip

  ChannelFifo #(.Width(PcWordW), .Depth(FifoDepth)) PcInFifo_i (
    .clk, .arstN,
    .inValid(pcInValid), .inData(pcInData), .inReady(pcInReady),
    .outValid(pcFifoValid), .outData(pcFifoData), .outReady(pcFifoReady));

  PcParser PcParser_i (
    .clk, .arstN,
    .inValid(pcFifoValid), .inData(pcFifoData), .inReady(pcFifoReady),
    .bdValid, .bdLeaf, .bdData, .bdReady,
    .unitCycles, .hbUnits, .pReset, .sReset);

  BdEncoder BdEncoder_i (
    .clk, .arstN,
    .inValid(bdValid), .inLeaf(bdLeaf), .inData(bdData), .inReady(bdReady),
    .outValid(bdOutValid), .outData(bdOutData), .outReady(bdOutReady));

  //////////////////////////////////////////////////////////////
  // Chip to PC, heartbeats merged in

  TimeMgr TimeMgr_i (
    .clk, .arstN, .unitCycles, .hbUnits, .hbReq, .hbAck, .timeElapsed);

  ChannelFifo #(.Width(BdWordW), .Depth(FifoDepth)) BdInFifo_i (
    .clk, .arstN,
    .inValid(bdInValid), .inData(bdInData), .inReady(bdInReady),
    .outValid(bdFifoValid), .outData(bdFifoData), .outReady(bdFifoReady));

  PcPacker PcPacker_i (
    .clk, .arstN,
    .inValid(bdFifoValid), .inData(bdFifoData), .inReady(bdFifoReady),
    .hbReq, .hbAck, .timeElapsed,
    .outValid(pcOutValid), .outData(pcOutData), .outReady(pcOutReady));

endmodule

// ==== verilog/CorePkg.sv ====
package CorePkg;

  //////////////////////////////////////////////////////////////
  // PC word layout

  localparam int PcCodeW = 8;
  localparam int PcDataW = 24;
  localparam int PcWordW = PcCodeW + PcDataW;

  //////////////////////////////////////////////////////////////
  // Chip word layout, route on top of payload

  localparam int RouteW = 4;
  localparam int BdWordW = RouteW + PcDataW;
  localparam int NumLeaves = 8;
  localparam int LeafW = $clog2(NumLeaves);
  localparam int LeafWidthW = 5;

  // Route code per leaf, leaf 7 first
  localparam logic [NumLeaves-1:0][RouteW-1:0] LeafRoute = {
    4'hE, 4'hC, 4'h9, 4'h8, 4'h5, 4'h4, 4'h2, 4'h0
  };

  // Payload bits kept per leaf, leaf 7 first
  localparam logic [NumLeaves-1:0][LeafWidthW-1:0] LeafWidth = {
    5'd1, 5'd4, 5'd8, 5'd10, 5'd12, 5'd16, 5'd20, 5'd24
  };

  //////////////////////////////////////////////////////////////
  // PC codes

  localparam logic [PcCodeW-1:0] CodeBdBase = 8'h80;
  localparam logic [PcCodeW-1:0] CodeBdLast = CodeBdBase + PcCodeW'(NumLeaves - 1);
  localparam logic [PcCodeW-1:0] CodeRegUnit = 8'h00;
  localparam logic [PcCodeW-1:0] CodeRegHb = 8'h01;
  localparam logic [PcCodeW-1:0] CodeRegReset = 8'h02;
  // Upper end of register space, 0x03 and up are spare
  localparam logic [PcCodeW-1:0] CodeRegLast = 8'h07;
  localparam logic [PcCodeW-1:0] CodeHbLo = 8'h40;
  localparam logic [PcCodeW-1:0] CodeHbHi = 8'h41;

  // Config register and time widths
  localparam int RegW = 16;
  localparam int TimeW = 48;
  localparam int FifoDepth = 4;

  typedef enum logic [1:0] {OpRegWrite, OpBdWord, OpDrop} PcOp;
  typedef enum logic [1:0] {PackData, PackHbLo, PackHbHi} PackState;

endpackage

// ==== verilog/PcPacker.sv ====
module PcPacker (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          inValid,
  input  logic [CorePkg::BdWordW-1:0]   inData,
  output logic                          inReady,
  input  logic                          hbReq,
  output logic                          hbAck,
  input  logic [CorePkg::TimeW-1:0]     timeElapsed,
  output logic                          outValid,
  output logic [CorePkg::PcWordW-1:0]   outData,
  input  logic                          outReady
);

  import CorePkg::*;

  PackState state;
  logic [TimeW-1:0] hbTime;
  logic [PcCodeW-1:0] upCode;
  logic loadEn;
  logic hbStart;
  logic dataTake;

  // Output register free or draining
  assign loadEn = !outValid || outReady;
  // Heartbeat wins over new data so traffic cannot starve it
  assign hbStart = state == PackData && loadEn && hbReq;
  assign hbAck = hbStart;
  assign inReady = state == PackData && loadEn && !hbReq;
  assign dataTake = inValid && inReady;
  // Upstream code from the route field
  assign upCode = CodeBdBase + PcCodeW'(inData[BdWordW-1 -: RouteW]);

  //////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= PackData;
      outValid <= 1'b0;
    end else begin
      case (state)
        PackData: if (loadEn) begin
          outValid <= dataTake;
          if (hbStart) state <= PackHbLo;
        end
        // Output is empty here, HbLo loads at once
        PackHbLo: begin
          outValid <= 1'b1;
          state <= PackHbHi;
        end
        PackHbHi: if (loadEn) begin
          outValid <= 1'b1;
          state <= PackData;
        end
        default: state <= PackData;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////
  // Payload

  always_ff @(posedge clk) begin
    // Time snapshot at the ack
    if (hbStart) hbTime <= timeElapsed;
    if (dataTake) outData <= {upCode, inData[PcDataW-1:0]};
    else if (state == PackHbLo) outData <= {CodeHbLo, hbTime[PcDataW-1:0]};
    else if (state == PackHbHi && loadEn) outData <= {CodeHbHi, hbTime[TimeW-1:PcDataW]};
  end

endmodule

// ==== verilog/PcParser.sv ====
module PcParser (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          inValid,
  input  logic [CorePkg::PcWordW-1:0]   inData,
  output logic                          inReady,
  output logic                          bdValid,
  output logic [CorePkg::LeafW-1:0]     bdLeaf,
  output logic [CorePkg::PcDataW-1:0]   bdData,
  input  logic                          bdReady,
  output logic [CorePkg::RegW-1:0]      unitCycles,
  output logic [CorePkg::RegW-1:0]      hbUnits,
  output logic                          pReset,
  output logic                          sReset
);

  import CorePkg::*;

  logic [PcCodeW-1:0] code;
  logic [PcDataW-1:0] data;
  PcOp op;
  logic take;

  // Split PC word
  assign code = inData[PcWordW-1 -: PcCodeW];
  assign data = inData[PcDataW-1:0];

  // Output slot empty or draining
  assign inReady = !bdValid || bdReady;
  assign take = inValid && inReady;

  // Code decode
  always_comb begin
    op = OpDrop;
    if (code <= CodeRegLast) op = OpRegWrite;
    else if (code >= CodeBdBase && code <= CodeBdLast) op = OpBdWord;
  end

  //////////////////////////////////////////////////////////////
  // Config registers

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      unitCycles <= '0;
      hbUnits <= '0;
      // Chip held in reset until host releases it
      pReset <= 1'b1;
      sReset <= 1'b1;
    end else if (take && op == OpRegWrite) begin
      case (code)
        CodeRegUnit: unitCycles <= data[RegW-1:0];
        CodeRegHb: hbUnits <= data[RegW-1:0];
        CodeRegReset: begin
          pReset <= data[0];
          sReset <= data[1];
        end
        // Spare register codes
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////
  // Downstream output slot

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) bdValid <= 1'b0;
    else if (inReady) bdValid <= take && op == OpBdWord;
  end

  // Leaf index is the low bits of the code
  always_ff @(posedge clk) begin
    if (take && op == OpBdWord) begin
      bdLeaf <= code[LeafW-1:0];
      bdData <= data;
    end
  end

  // Downstream word held under stall
  holdOut: assert property (@(posedge clk) disable iff (!arstN)
    bdValid && !bdReady |=> bdValid && $stable(bdLeaf) && $stable(bdData));

endmodule

// ==== verilog/TimeMgr.sv ====
module TimeMgr (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic [CorePkg::RegW-1:0]    unitCycles,
  input  logic [CorePkg::RegW-1:0]    hbUnits,
  output logic                        hbReq,
  input  logic                        hbAck,
  output logic [CorePkg::TimeW-1:0]   timeElapsed
);

  import CorePkg::*;

  logic [RegW-1:0] cycleCnt;
  logic [RegW-1:0] unitCnt;
  logic unitPulse;
  logic hbDue;

  // Compare with >= so a shrunk unitCycles still wraps at once
  assign unitPulse = unitCycles != '0 && cycleCnt >= unitCycles - 1'b1;
  // Last unit of a heartbeat period
  assign hbDue = unitPulse && hbUnits != '0 && unitCnt >= hbUnits - 1'b1;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cycleCnt <= '0;
      unitCnt <= '0;
      timeElapsed <= '0;
      hbReq <= 1'b0;
    end else begin
      // Cycles within a unit, parked while time is stopped
      if (unitCycles == '0 || unitPulse) cycleCnt <= '0;
      else cycleCnt <= cycleCnt + 1'b1;

      // Elapsed time runs regardless of back-pressure
      if (unitPulse) timeElapsed <= timeElapsed + 1'b1;

      // Units within a heartbeat period
      if (hbUnits == '0 || hbDue) unitCnt <= '0;
      else if (unitPulse) unitCnt <= unitCnt + 1'b1;

      // New due merges into a pending request
      hbReq <= hbDue || (hbReq && !hbAck);
    end
  end

  // Packer only acks an open request
  ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
    hbAck |-> hbReq);

endmodule
